//--- vlog.f
rtl/simt_pkg.sv
rtl/commit_if.sv
rtl/pipe_register.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/writeback_arbiter.sv
rtl/exec_writeback_top.sv
dv/wb_checker.sv
dv/tb_top.sv

//--- Bender.yml
package:
  name: exec_writeback

sources:
  # package first, then interfaces and the design bottom up.
  - rtl/simt_pkg.sv
  - rtl/commit_if.sv
  - rtl/pipe_register.sv
  - rtl/alu_unit.sv
  - rtl/mul_unit.sv
  - rtl/writeback_arbiter.sv
  - rtl/exec_writeback_top.sv
  - target: simulation
    files:
      - dv/wb_checker.sv
      - dv/tb_top.sv

//--- dv/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top import simt_pkg::*; ();

    localparam int num_tests  = 400;
    localparam int stall_pct  = 30;
    localparam int max_cycles = num_tests * 20 + 300;
    localparam int wid_bits   = id_bits(num_warps);

    logic                         clk;
    logic                         reset;
    logic                         issue_valid;
    wire                          issue_ready;
    op_t                          issue_op;
    logic [wid_bits-1:0]          issue_wid;
    logic [31:0]                  issue_pc;
    logic [num_threads-1:0]       issue_tmask;
    logic [rd_bits-1:0]           issue_rd;
    logic                         issue_wb;
    logic [num_threads-1:0][31:0] issue_a;
    logic [num_threads-1:0][31:0] issue_b;
    wire                          wb_valid;
    logic                         wb_ready;
    wire  [wid_bits-1:0]          wb_wid;
    wire  [31:0]                  wb_pc;
    wire  [num_threads-1:0]       wb_tmask;
    wire  [rd_bits-1:0]           wb_rd;
    wire  [num_threads-1:0][31:0] wb_data;
    int                           value_errors;
    int                           protocol_errors;
    int                           pending;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // next instruction, unique pc per index.
    task automatic load_instruction(int index);
        logic [num_threads-1:0][31:0] a_next;
        logic [num_threads-1:0][31:0] b_next;
        for (int i = 0; i < num_threads; i++) begin
            a_next[i] = $urandom;
            b_next[i] = $urandom;
        end
        issue_valid <= 1'b1;
        issue_op    <= $urandom_range(0, 9);
        issue_wid   <= $urandom_range(0, num_warps - 1);
        issue_pc    <= 32'h1000 + index * 4;
        issue_tmask <= $urandom_range(0, (1 << num_threads) - 1);
        issue_rd    <= $urandom_range(0, num_regs - 1);
        issue_wb    <= ($urandom_range(0, 7) != 0);
        issue_a     <= a_next;
        issue_b     <= b_next;
    endtask

    initial begin : stimulus
        int issued;
        int loaded;
        int drain;
        issued = 0;
        loaded = 0;
        drain  = 0;
        void'($urandom(32'h6f86));
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = op_add;
        issue_wid   = '0;
        issue_pc    = '0;
        issue_tmask = '0;
        issue_rd    = '0;
        issue_wb    = 1'b0;
        issue_a     = '0;
        issue_b     = '0;
        wb_ready    = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // gaps in issue about one cycle in four.
        while (issued < num_tests) begin
            @(posedge clk);
            if (issue_valid && issue_ready) issued++;
            if (!issue_valid || issue_ready) begin
                if (loaded < num_tests && $urandom_range(0, 3) != 0) begin
                    load_instruction(loaded);
                    loaded++;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
        end

        do begin
            @(negedge clk);
            drain++;
        end while (pending != 0 && drain < 200);
        repeat (4) @(negedge clk);

        if (pending != 0) begin
            $display("Error: %0d expected writebacks never reached the port", pending);
        end
        $display("checks done: %0d value errors, %0d protocol errors, %0d writebacks missing",
                 value_errors, protocol_errors, pending);
        if (value_errors == 0 && protocol_errors == 0 && pending == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // register file back-pressure.
    always @(posedge clk) begin
        if (!reset) begin
            wb_ready <= ($urandom_range(0, 99) >= stall_pct);
        end
    end

    initial begin : watchdog
        repeat (max_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Verification failed");
        $finish;
    end

    exec_writeback_top #(
        .NUM_THREADS (num_threads),
        .NUM_WARPS   (num_warps)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_wid   (issue_wid),
        .issue_pc    (issue_pc),
        .issue_tmask (issue_tmask),
        .issue_rd    (issue_rd),
        .issue_wb    (issue_wb),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_wid      (wb_wid),
        .wb_pc       (wb_pc),
        .wb_tmask    (wb_tmask),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    wb_checker #(
        .NUM_THREADS (num_threads),
        .NUM_WARPS   (num_warps)
    ) chk0 (
        .clk             (clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .issue_op        (issue_op),
        .issue_wid       (issue_wid),
        .issue_pc        (issue_pc),
        .issue_tmask     (issue_tmask),
        .issue_rd        (issue_rd),
        .issue_wb        (issue_wb),
        .issue_a         (issue_a),
        .issue_b         (issue_b),
        .wb_valid        (wb_valid),
        .wb_ready        (wb_ready),
        .wb_wid          (wb_wid),
        .wb_pc           (wb_pc),
        .wb_tmask        (wb_tmask),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

endmodule

`default_nettype wire

//--- dv/wb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module wb_checker import simt_pkg::*; #(
    parameter int  NUM_THREADS = num_threads,
    parameter int  NUM_WARPS   = num_warps,
    localparam int wid_bits    = id_bits(NUM_WARPS)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         issue_valid,
    input  wire                         issue_ready,
    input  op_t                         issue_op,
    input  wire [wid_bits-1:0]          issue_wid,
    input  wire [31:0]                  issue_pc,
    input  wire [NUM_THREADS-1:0]       issue_tmask,
    input  wire [rd_bits-1:0]           issue_rd,
    input  wire                         issue_wb,
    input  wire [NUM_THREADS-1:0][31:0] issue_a,
    input  wire [NUM_THREADS-1:0][31:0] issue_b,
    input  wire                         wb_valid,
    input  wire                         wb_ready,
    input  wire [wid_bits-1:0]          wb_wid,
    input  wire [31:0]                  wb_pc,
    input  wire [NUM_THREADS-1:0]       wb_tmask,
    input  wire [rd_bits-1:0]           wb_rd,
    input  wire [NUM_THREADS-1:0][31:0] wb_data,
    output int                          value_errors,
    output int                          protocol_errors,
    output int                          pending
);
    localparam int out_bits = wid_bits + 32 + NUM_THREADS + rd_bits + NUM_THREADS * 32;

    typedef struct packed {
        logic                         is_mul;
        logic [wid_bits-1:0]          wid;
        logic [NUM_THREADS-1:0]       tmask;
        logic [rd_bits-1:0]           rd;
        logic [NUM_THREADS-1:0][31:0] data;
    } entry_t;

    entry_t              expected[logic [31:0]];
    logic [31:0]         order[$];
    logic                held = 1'b0;
    logic [out_bits-1:0] held_out;

    // one lane of the expected result.
    function automatic logic [31:0] ref_lane(op_t op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] prod;
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_and:    return a & b;
            op_or:     return a | b;
            op_xor:    return a ^ b;
            op_sll:    return a << b[4:0];
            op_srl:    return a >> b[4:0];
            op_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_mul_lo: return prod[31:0];
            op_mul_hi: return prod[63:32];
            default:   return 32'd0;
        endcase
    endfunction

    task automatic value_check(string name, logic [63:0] exp_val, logic [63:0] act_val);
        if (exp_val !== act_val) begin
            value_errors++;
            $display("Fail %0t %s: expected %0h, got %0h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic protocol_error(string what);
        protocol_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin : watch
        entry_t e;
        int     due;
        int     found;
        if (reset) begin
            held = 1'b0;
        end else begin
            // a stalled writeback must sit still.
            if (held && held_out !== {wb_wid, wb_pc, wb_tmask, wb_rd, wb_data}) begin
                protocol_error("writeback outputs changed while the port was stalled");
            end
            if (held && !wb_valid) begin
                protocol_error("wb_valid dropped while the port was stalled");
            end

            if (issue_valid && issue_ready && issue_wb) begin
                e.is_mul = is_mul_op(issue_op);
                e.wid    = issue_wid;
                e.tmask  = issue_tmask;
                e.rd     = issue_rd;
                for (int i = 0; i < NUM_THREADS; i++) begin
                    e.data[i] = issue_tmask[i] ? ref_lane(issue_op, issue_a[i], issue_b[i]) : 0;
                end
                expected[issue_pc] = e;
                order.push_back(issue_pc);
            end

            if (wb_valid && wb_ready) begin
                if (!expected.exists(wb_pc)) begin
                    protocol_error($sformatf("writeback of pc %h that was never expected", wb_pc));
                end else begin
                    e = expected[wb_pc];
                    value_check("wb_wid", e.wid, wb_wid);
                    value_check("wb_tmask", e.tmask, wb_tmask);
                    value_check("wb_rd", e.rd, wb_rd);
                    for (int i = 0; i < NUM_THREADS; i++) begin
                        value_check($sformatf("wb_data[%0d]", i), e.data[i], wb_data[i]);
                    end
                    // oldest pending pc of the same unit is due next.
                    due   = -1;
                    found = -1;
                    for (int k = 0; k < order.size(); k++) begin
                        if (due < 0 && expected[order[k]].is_mul == e.is_mul) due = k;
                        if (order[k] == wb_pc) found = k;
                    end
                    if (order[due] != wb_pc) begin
                        protocol_error($sformatf("pc %h left its unit before pc %h",
                                                 wb_pc, order[due]));
                    end
                    order.delete(found);
                    expected.delete(wb_pc);
                end
            end

            held     = wb_valid && !wb_ready;
            held_out = {wb_wid, wb_pc, wb_tmask, wb_rd, wb_data};
        end
        pending = expected.num();
    end

endmodule

`default_nettype wire

//--- rtl/exec_writeback_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_writeback_top import simt_pkg::*; #(
    parameter int  NUM_THREADS = num_threads,
    parameter int  NUM_WARPS   = num_warps,
    localparam int wid_bits    = id_bits(NUM_WARPS)
) (
    input  wire                          clk,
    input  wire                          reset,

    input  wire                          issue_valid,
    output logic                         issue_ready,
    input  op_t                          issue_op,
    input  wire [wid_bits-1:0]           issue_wid,
    input  wire [31:0]                   issue_pc,
    input  wire [NUM_THREADS-1:0]        issue_tmask,
    input  wire [rd_bits-1:0]            issue_rd,
    input  wire                          issue_wb,
    input  wire [NUM_THREADS-1:0][31:0]  issue_a,
    input  wire [NUM_THREADS-1:0][31:0]  issue_b,

    output logic                         wb_valid,
    input  wire                          wb_ready,
    output logic [wid_bits-1:0]          wb_wid,
    output logic [31:0]                  wb_pc,
    output logic [NUM_THREADS-1:0]       wb_tmask,
    output logic [rd_bits-1:0]           wb_rd,
    output logic [NUM_THREADS-1:0][31:0] wb_data
);

    logic to_mul;

    issue_if #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) alu_issue ();
    issue_if #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) mul_issue ();
    commit_if #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) alu_commit ();
    commit_if #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) mul_commit ();

    // steer by operation class.
    assign to_mul          = is_mul_op(issue_op);
    assign alu_issue.valid = issue_valid && !to_mul;
    assign mul_issue.valid = issue_valid && to_mul;
    assign issue_ready     = to_mul ? mul_issue.ready : alu_issue.ready;

    // payload goes to both units.
    assign alu_issue.op    = issue_op;
    assign alu_issue.wid   = issue_wid;
    assign alu_issue.pc    = issue_pc;
    assign alu_issue.tmask = issue_tmask;
    assign alu_issue.rd    = issue_rd;
    assign alu_issue.wb    = issue_wb;
    assign alu_issue.a     = issue_a;
    assign alu_issue.b     = issue_b;

    assign mul_issue.op    = issue_op;
    assign mul_issue.wid   = issue_wid;
    assign mul_issue.pc    = issue_pc;
    assign mul_issue.tmask = issue_tmask;
    assign mul_issue.rd    = issue_rd;
    assign mul_issue.wb    = issue_wb;
    assign mul_issue.a     = issue_a;
    assign mul_issue.b     = issue_b;

    alu_unit #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) alu0 (
        .clk    (clk),
        .reset  (reset),
        .issue  (alu_issue.slave),
        .commit (alu_commit.master)
    );

    mul_unit #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) mul0 (
        .clk    (clk),
        .reset  (reset),
        .issue  (mul_issue.slave),
        .commit (mul_commit.master)
    );

    writeback_arbiter #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) arb0 (
        .clk        (clk),
        .reset      (reset),
        .alu_commit (alu_commit.slave),
        .mul_commit (mul_commit.slave),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_wid     (wb_wid),
        .wb_pc      (wb_pc),
        .wb_tmask   (wb_tmask),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

//--- rtl/writeback_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_arbiter import simt_pkg::*; #(
    parameter int  NUM_THREADS = num_threads,
    parameter int  NUM_WARPS   = num_warps,
    localparam int wid_bits    = id_bits(NUM_WARPS)
) (
    input  wire                          clk,
    input  wire                          reset,
    commit_if.slave                      alu_commit,
    commit_if.slave                      mul_commit,
    output logic                         wb_valid,
    input  wire                          wb_ready,
    output logic [wid_bits-1:0]          wb_wid,
    output logic [31:0]                  wb_pc,
    output logic [NUM_THREADS-1:0]       wb_tmask,
    output logic [rd_bits-1:0]           wb_rd,
    output logic [NUM_THREADS-1:0][31:0] wb_data
);

    typedef struct packed {
        logic [wid_bits-1:0]          wid;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0]       tmask;
        logic [rd_bits-1:0]           rd;
        logic [NUM_THREADS-1:0][31:0] data;
    } writeback_t;

    logic       alu_req;
    logic       mul_req;
    logic       stall;
    writeback_t sel;
    writeback_t out_q;

    // only commits that write the register file compete.
    assign alu_req = alu_commit.valid && alu_commit.wb;
    assign mul_req = mul_commit.valid && mul_commit.wb;
    assign stall   = wb_valid && !wb_ready;

    // readies also drain wb-clear commits.
    assign alu_commit.ready = !stall;
    assign mul_commit.ready = !stall && !alu_req;

    always_comb begin
        if (alu_req) begin
            sel.wid   = alu_commit.wid;
            sel.pc    = alu_commit.pc;
            sel.tmask = alu_commit.tmask;
            sel.rd    = alu_commit.rd;
            sel.data  = alu_commit.data;
        end else begin
            sel.wid   = mul_commit.wid;
            sel.pc    = mul_commit.pc;
            sel.tmask = mul_commit.tmask;
            sel.rd    = mul_commit.rd;
            sel.data  = mul_commit.data;
        end
    end

    pipe_register #(.T(writeback_t)) out_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (!stall),
        .valid_in  (alu_req || mul_req),
        .data_in   (sel),
        .valid_out (wb_valid),
        .data_out  (out_q)
    );

    assign wb_wid   = out_q.wid;
    assign wb_pc    = out_q.pc;
    assign wb_tmask = out_q.tmask;
    assign wb_rd    = out_q.rd;
    assign wb_data  = out_q.data;

endmodule

`default_nettype wire

//--- rtl/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit import simt_pkg::*; #(
    parameter int NUM_THREADS = num_threads,
    parameter int NUM_WARPS   = num_warps
) (
    input wire       clk,
    input wire       reset,
    issue_if.slave   issue,
    commit_if.master commit
);
    localparam int wid_bits = id_bits(NUM_WARPS);

    typedef struct packed {
        logic [wid_bits-1:0]    wid;
        logic [31:0]            pc;
        logic [NUM_THREADS-1:0] tmask;
        logic [rd_bits-1:0]     rd;
        logic                   wb;
    } commit_hdr_t;

    typedef struct packed {
        commit_hdr_t                  hdr;
        op_t                          op;
        logic [NUM_THREADS-1:0][31:0] a;
        logic [NUM_THREADS-1:0][31:0] b;
    } operand_t;

    typedef struct packed {
        commit_hdr_t                  hdr;
        logic                         hi;
        logic [NUM_THREADS-1:0][63:0] prod;
    } product_t;

    typedef struct packed {
        commit_hdr_t                  hdr;
        logic [NUM_THREADS-1:0][31:0] data;
    } commit_t;

    wire [NUM_THREADS-1:0][63:0] lane_prod;
    wire [NUM_THREADS-1:0][31:0] lane_data;
    logic     advance;
    logic     s1_valid;
    logic     s2_valid;
    operand_t s1_d;
    operand_t s1_q;
    product_t s2_d;
    product_t s2_q;
    commit_t  s3_d;
    commit_t  s3_q;

    // whole pipe moves as one.
    assign advance     = !commit.valid || commit.ready;
    assign issue.ready = advance;

    always_comb begin
        s1_d.hdr.wid   = issue.wid;
        s1_d.hdr.pc    = issue.pc;
        s1_d.hdr.tmask = issue.tmask;
        s1_d.hdr.rd    = issue.rd;
        s1_d.hdr.wb    = issue.wb;
        s1_d.op        = issue.op;
        s1_d.a         = issue.a;
        s1_d.b         = issue.b;
    end

    pipe_register #(.T(operand_t)) s1_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .valid_in  (issue.valid),
        .data_in   (s1_d),
        .valid_out (s1_valid),
        .data_out  (s1_q)
    );

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        // signed operands extend to the full 64-bit product.
        assign lane_prod[i] = $signed(s1_q.a[i]) * $signed(s1_q.b[i]);
        assign lane_data[i] = !s2_q.hdr.tmask[i] ? 32'b0 :
                              s2_q.hi ? s2_q.prod[i][63:32] : s2_q.prod[i][31:0];
    end

    assign s2_d.hdr  = s1_q.hdr;
    assign s2_d.hi   = (s1_q.op == op_mul_hi);
    assign s2_d.prod = lane_prod;

    pipe_register #(.T(product_t)) s2_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .valid_in  (s1_valid),
        .data_in   (s2_d),
        .valid_out (s2_valid),
        .data_out  (s2_q)
    );

    assign s3_d.hdr  = s2_q.hdr;
    assign s3_d.data = lane_data;

    pipe_register #(.T(commit_t)) s3_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .valid_in  (s2_valid),
        .data_in   (s3_d),
        .valid_out (commit.valid),
        .data_out  (s3_q)
    );

    assign commit.wid   = s3_q.hdr.wid;
    assign commit.pc    = s3_q.hdr.pc;
    assign commit.tmask = s3_q.hdr.tmask;
    assign commit.rd    = s3_q.hdr.rd;
    assign commit.wb    = s3_q.hdr.wb;
    assign commit.data  = s3_q.data;

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit import simt_pkg::*; #(
    parameter int NUM_THREADS = num_threads,
    parameter int NUM_WARPS   = num_warps
) (
    input wire       clk,
    input wire       reset,
    issue_if.slave   issue,
    commit_if.master commit
);
    localparam int wid_bits = id_bits(NUM_WARPS);

    typedef struct packed {
        logic [wid_bits-1:0]    wid;
        logic [31:0]            pc;
        logic [NUM_THREADS-1:0] tmask;
        logic [rd_bits-1:0]     rd;
        logic                   wb;
    } commit_hdr_t;

    typedef struct packed {
        commit_hdr_t                  hdr;
        logic [NUM_THREADS-1:0][31:0] data;
    } commit_t;

    wire [NUM_THREADS-1:0][31:0] lane_data;
    logic                        advance;
    commit_t                     result_d;
    commit_t                     result_q;

    // accept when the result slot frees up this cycle.
    assign advance     = !commit.valid || commit.ready;
    assign issue.ready = advance;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        logic [31:0] res;

        always_comb begin
            case (issue.op)
                op_add:  res = issue.a[i] + issue.b[i];
                op_sub:  res = issue.a[i] - issue.b[i];
                op_and:  res = issue.a[i] & issue.b[i];
                op_or:   res = issue.a[i] | issue.b[i];
                op_xor:  res = issue.a[i] ^ issue.b[i];
                op_sll:  res = issue.a[i] << issue.b[i][4:0];
                op_srl:  res = issue.a[i] >> issue.b[i][4:0];
                op_slt:  res = {31'b0, $signed(issue.a[i]) < $signed(issue.b[i])};
                default: res = '0;
            endcase
        end

        // inactive lanes read zero.
        assign lane_data[i] = issue.tmask[i] ? res : 32'b0;
    end

    always_comb begin
        result_d.hdr.wid   = issue.wid;
        result_d.hdr.pc    = issue.pc;
        result_d.hdr.tmask = issue.tmask;
        result_d.hdr.rd    = issue.rd;
        result_d.hdr.wb    = issue.wb;
        result_d.data      = lane_data;
    end

    pipe_register #(
        .T (commit_t)
    ) result_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .valid_in  (issue.valid),
        .data_in   (result_d),
        .valid_out (commit.valid),
        .data_out  (result_q)
    );

    assign commit.wid   = result_q.hdr.wid;
    assign commit.pc    = result_q.hdr.pc;
    assign commit.tmask = result_q.hdr.tmask;
    assign commit.rd    = result_q.hdr.rd;
    assign commit.wb    = result_q.hdr.wb;
    assign commit.data  = result_q.data;

endmodule

`default_nettype wire

//--- rtl/pipe_register.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_register #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  enable,
    input  wire  valid_in,
    input  T     data_in,
    output logic valid_out,
    output T     data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    // payload follows the valid bit.
    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- rtl/commit_if.sv
`timescale 1ns/10ps
`default_nettype none

interface issue_if import simt_pkg::*; #(
    parameter int NUM_THREADS = num_threads,
    parameter int NUM_WARPS   = num_warps
);
    localparam int wid_bits = id_bits(NUM_WARPS);

    logic                         valid;
    logic                         ready;
    op_t                          op;
    logic [wid_bits-1:0]          wid;
    logic [31:0]                  pc;
    logic [NUM_THREADS-1:0]       tmask;
    logic [rd_bits-1:0]           rd;
    logic                         wb;
    logic [NUM_THREADS-1:0][31:0] a;
    logic [NUM_THREADS-1:0][31:0] b;

    modport master (output valid, op, wid, pc, tmask, rd, wb, a, b, input ready);
    modport slave (input valid, op, wid, pc, tmask, rd, wb, a, b, output ready);

endinterface

interface commit_if import simt_pkg::*; #(
    parameter int NUM_THREADS = num_threads,
    parameter int NUM_WARPS   = num_warps
);
    localparam int wid_bits = id_bits(NUM_WARPS);

    logic                         valid;
    logic                         ready;
    logic [wid_bits-1:0]          wid;
    logic [31:0]                  pc;
    logic [NUM_THREADS-1:0]       tmask;
    logic [rd_bits-1:0]           rd;
    logic                         wb;
    logic [NUM_THREADS-1:0][31:0] data;

    modport master (output valid, wid, pc, tmask, rd, wb, data, input ready);
    modport slave (input valid, wid, pc, tmask, rd, wb, data, output ready);

endinterface

`default_nettype wire

//--- rtl/simt_pkg.sv
`default_nettype none

package simt_pkg;

    // default warp geometry.
    localparam int num_threads = 4;
    localparam int num_warps   = 4;

    localparam int num_regs = 32;
    localparam int rd_bits  = $clog2(num_regs);

    typedef logic [3:0] op_t;

    // alu class, upper bit clear.
    localparam op_t op_add = 4'h0;
    localparam op_t op_sub = 4'h1;
    localparam op_t op_and = 4'h2;
    localparam op_t op_or  = 4'h3;
    localparam op_t op_xor = 4'h4;
    localparam op_t op_sll = 4'h5;
    localparam op_t op_srl = 4'h6;
    localparam op_t op_slt = 4'h7;

    // multiplier class, upper bit set.
    localparam op_t op_mul_lo = 4'h8;
    localparam op_t op_mul_hi = 4'h9;

    function automatic logic is_mul_op(op_t op);
        return op[3];
    endfunction

    // index width for a count of items, never below one bit.
    function automatic int id_bits(int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage

`default_nettype wire
